// ==== sim.f ====
src/ghash_pkg.sv
src/gf32_mult.sv
src/ghash_core.sv
src/auth_sequencer.sv
src/gcm_auth_top.sv
dv/gcm_auth_tb.sv

// ==== Bender.yml ====
package:
  name: gcm_auth

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - src/ghash_pkg.sv
  - src/gf32_mult.sv
  - src/ghash_core.sv
  - src/auth_sequencer.sv
  - src/gcm_auth_top.sv

  # testbench, top module gcm_auth_tb
  - target: test
    files:
      - dv/gcm_auth_tb.sv

// ==== dv/gcm_auth_tb.sv ====
// drives inputs on the falling edge, keys change only after the previous tag is out; stops at first error
module gcm_auth_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ghash_pkg::*;

    localparam int N_RANDOM = 30; // mixed aad/text messages with gaps
    localparam int N_B2B    = 12; // back-to-back burst, one key
    localparam int N_KEYED  = 6;  // h_key of 1 and keys with high bits set
    localparam int N_MSGS   = 1 + N_RANDOM + N_B2B + N_KEYED + 2;
    localparam int TIMEOUT_CYC = (N_MSGS * 20) + 100;

    logic   clk;
    logic   reset_l;
    block_t h_key;
    block_t tag_mask;
    logic   data_valid;
    block_t data_in;
    kind_e  data_kind;
    logic   last_block;
    block_t auth_tag;
    logic   tag_valid;

    logic [31:0] lfsr = 32'h6950_21c0;
    int          cyc = 0;       // posedge count
    block_t      msg_blocks [0:15];
    block_t      exp_tags [$];
    int          exp_cycles [$]; // cyc value when tag_valid must be seen

    gcm_auth_top i_dut (
        .clk        (clk),
        .reset_l    (reset_l),
        .h_key      (h_key),
        .tag_mask   (tag_mask),
        .data_valid (data_valid),
        .data_in    (data_in),
        .data_kind  (data_kind),
        .last_block (last_block),
        .auth_tag   (auth_tag),
        .tag_valid  (tag_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // shift-and-add multiply, reducing the shifted operand each step
    function automatic block_t gf_mul(input block_t x, input block_t y);
        block_t r;
        block_t s;
        r = '0;
        s = x;
        for (int i = 0; i < $bits(block_t); i++) begin
            if (y[i]) r = r ^ s;
            if (s[31]) begin
                s = (s << 1) ^ FIELD_POLY; // x^32 folds back
            end else begin
                s = s << 1;
            end
        end
        return r;
    endfunction

    function automatic block_t ref_tag(input int n_aad, input int n_text,
                                       input block_t key, input block_t mask);
        block_t acc;
        block_t len;
        acc = '0;
        for (int i = 0; i < n_aad + n_text; i++) begin
            acc = gf_mul(acc ^ msg_blocks[i], key);
        end
        len = {count_t'(n_aad), count_t'(n_text)};
        acc = gf_mul(acc ^ len, key);
        return acc ^ mask;
    endfunction

    // with h_key of 1 every multiply is the identity
    function automatic block_t xor_tag(input int n_aad, input int n_text, input block_t mask);
        block_t acc;
        acc = mask ^ {count_t'(n_aad), count_t'(n_text)};
        for (int i = 0; i < n_aad + n_text; i++) begin
            acc = acc ^ msg_blocks[i];
        end
        return acc;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic apply_reset();
        reset_l    = 1'b0;
        data_valid = 1'b0;
        last_block = 1'b0;
        repeat (3) @(negedge clk);
        reset_l = 1'b1;
    endtask

    task automatic wait_tags_done();
        while (exp_tags.size() != 0) @(negedge clk);
    endtask

    task automatic set_keys(input block_t key, input block_t mask);
        wait_tags_done(); // mask is applied one edge after the length block
        h_key    = key;
        tag_mask = mask;
    endtask

    task automatic send_msg(input int n_aad, input int n_text, input bit gaps, input bit xor_ref);
        int          n_blk;
        logic [31:0] r;
        block_t      exp;
        n_blk = n_aad + n_text;
        for (int i = 0; i < n_blk; i++) begin
            rand_bits(32, r);
            msg_blocks[i] = r;
        end
        if (xor_ref) begin
            exp = xor_tag(n_aad, n_text, tag_mask);
        end else begin
            exp = ref_tag(n_aad, n_text, h_key, tag_mask);
        end
        for (int i = 0; i < n_blk; i++) begin
            if (gaps && i > 0) begin
                rand_bits(2, r);
                if (r[1:0] == 2'b11) begin
                    rand_bits(1, r);
                    repeat (1 + r[0]) begin // idle gap of 1 or 2 cycles
                        @(negedge clk);
                        data_valid = 1'b0;
                    end
                end
            end
            @(negedge clk);
            data_valid = 1'b1;
            data_in    = msg_blocks[i];
            data_kind  = (i < n_aad) ? KIND_AAD : KIND_TEXT;
            last_block = (i == n_blk - 1);
            if (i == n_blk - 1) begin
                exp_tags.push_back(exp);
                exp_cycles.push_back(cyc + 3); // sampled at cyc+1, tag two edges later
            end
        end
        @(negedge clk); // required idle cycle
        data_valid = 1'b0;
        last_block = 1'b0;
    endtask

    // some blocks, then reset before last_block
    task automatic reset_mid_msg();
        logic [31:0] r;
        for (int i = 0; i < 3; i++) begin
            rand_bits(32, r);
            @(negedge clk);
            data_valid = 1'b1;
            data_in    = r;
            data_kind  = (i == 0) ? KIND_AAD : KIND_TEXT;
            last_block = 1'b0;
        end
        @(negedge clk);
        apply_reset();
    endtask

    // timeout
    always @(posedge clk) begin
        cyc <= cyc + 1;
        assert (cyc < TIMEOUT_CYC)
            else fail_run("timeout: run did not finish within the cycle limit");
    end

    // comparing process, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (tag_valid) begin
            assert (exp_tags.size() != 0)
                else fail_run("tag_valid seen while no tag was expected");
            assert (exp_cycles[0] == cyc)
                else fail_run("tag_valid did not come two edges after last_block");
            assert (auth_tag === exp_tags[0])
                else fail_run($sformatf("FAILED at %0d ns: auth_tag expected %h actual %h",
                                        $time, exp_tags[0], auth_tag));
            void'(exp_tags.pop_front());
            void'(exp_cycles.pop_front());
        end else begin
            assert (exp_cycles.size() == 0 || exp_cycles[0] >= cyc)
                else fail_run("expected tag_valid never came");
        end
    end

    initial begin
        logic [31:0] k;
        logic [31:0] m;
        logic [31:0] na;
        logic [31:0] nt;
        h_key      = '0;
        tag_mask   = '0;
        data_valid = 1'b0;
        data_in    = '0;
        data_kind  = KIND_AAD;
        last_block = 1'b0;
        reset_l    = 1'b0;
        apply_reset();

        // single text block
        rand_bits(32, k);
        rand_bits(32, m);
        set_keys(k, m);
        send_msg(0, 1, 1'b0, 1'b0);

        // random mixes with gaps
        repeat (N_RANDOM) begin
            rand_bits(32, k);
            rand_bits(32, m);
            set_keys(k, m);
            rand_bits(3, na);
            rand_bits(3, nt);
            send_msg(int'(na[2:0]), int'(nt[2:0]) + 1, 1'b1, 1'b0);
        end

        // back to back, one idle cycle each
        rand_bits(32, k);
        rand_bits(32, m);
        set_keys(k, m);
        repeat (N_B2B) begin
            rand_bits(3, na);
            rand_bits(3, nt);
            send_msg(int'(na[2:0]), int'(nt[2:0]) + 1, 1'b0, 1'b0);
        end

        // identity key
        rand_bits(32, m);
        set_keys(32'h0000_0001, m);
        for (int i = 0; i < 3; i++) begin
            rand_bits(3, na);
            rand_bits(3, nt);
            send_msg(int'(na[2:0]), int'(nt[2:0]) + 1, 1'b0, 1'b1);
        end

        // high key bits push products into the reduction
        for (int i = 0; i < 3; i++) begin
            rand_bits(32, k);
            rand_bits(32, m);
            case (i)
                0:       k = {1'b1, k[30:0]};
                1:       k = 32'hFFFF_FFFF;
                default: k = {4'hF, k[27:0]};
            endcase
            set_keys(k, m);
            rand_bits(3, na);
            rand_bits(3, nt);
            send_msg(int'(na[2:0]), int'(nt[2:0]) + 1, 1'b1, 1'b0);
        end

        // reset inside a message, next one starts clean
        wait_tags_done();
        reset_mid_msg();
        rand_bits(32, k);
        rand_bits(32, m);
        set_keys(k, m);
        send_msg(2, 3, 1'b0, 1'b0);

        wait_tags_done();
        repeat (4) @(negedge clk); // catch stray pulses
        if (exp_tags.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("tags still expected at end of run");
        end
    end

endmodule

// ==== src/gcm_auth_top.sv ====
// no handshake: a block is taken on every data_valid, except in the cycle after last_block
module gcm_auth_top (
    input  logic              clk,
    input  logic              reset_l,
    input  ghash_pkg::block_t h_key,
    input  ghash_pkg::block_t tag_mask,
    input  logic              data_valid,
    input  ghash_pkg::block_t data_in,
    input  ghash_pkg::kind_e  data_kind,
    input  logic              last_block,
    output ghash_pkg::block_t auth_tag,
    output logic              tag_valid
);
    import ghash_pkg::*;

    logic   blk_valid;  // sequencer to core
    block_t blk_data;
    logic   blk_final;
    block_t mul_a;      // core to multiplier
    block_t mul_p;      // product back to core
    block_t hash;       // core to sequencer
    logic   hash_valid;

    auth_sequencer i_seq (
        .clk        (clk),
        .reset_l    (reset_l),
        .data_valid (data_valid),
        .data_in    (data_in),
        .data_kind  (data_kind),
        .last_block (last_block),
        .tag_mask   (tag_mask),
        .blk_valid  (blk_valid),
        .blk_data   (blk_data),
        .blk_final  (blk_final),
        .hash       (hash),
        .hash_valid (hash_valid),
        .auth_tag   (auth_tag),
        .tag_valid  (tag_valid)
    );

    ghash_core i_core (
        .clk        (clk),
        .reset_l    (reset_l),
        .h_key      (h_key),
        .blk_valid  (blk_valid),
        .blk_data   (blk_data),
        .blk_final  (blk_final),
        .mul_a      (mul_a),
        .mul_p      (mul_p),
        .hash       (hash),
        .hash_valid (hash_valid)
    );

    // key goes straight in as the second operand
    gf32_mult i_mult (
        .a (mul_a),
        .b (h_key),
        .p (mul_p)
    );

endmodule

// ==== src/auth_sequencer.sv ====
// source must idle one cycle after last_block and send aad before text; counters wrap at 2^16
module auth_sequencer (
    input  logic              clk,
    input  logic              reset_l,
    input  logic              data_valid,
    input  ghash_pkg::block_t data_in,
    input  ghash_pkg::kind_e  data_kind,
    input  logic              last_block,
    input  ghash_pkg::block_t tag_mask,
    output logic              blk_valid,
    output ghash_pkg::block_t blk_data,
    output logic              blk_final,
    input  ghash_pkg::block_t hash,
    input  logic              hash_valid,
    output ghash_pkg::block_t auth_tag,
    output logic              tag_valid
);
    import ghash_pkg::*;

    seq_state_e state;
    count_t     aad_count;  // aad blocks seen in this message
    count_t     text_count; // text blocks seen in this message
    logic       text_seen;  // a text block already went by
    logic       take;       // caller block accepted this cycle

    assign take = data_valid && (state == SEQ_DATA); // strobe in SEQ_LEN is dropped

    // block path to the core
    always_comb begin
        if (state == SEQ_LEN) begin
            blk_valid = 1'b1;
            blk_data  = {aad_count, text_count}; // aad high, text low
            blk_final = 1'b1;
        end else begin
            blk_valid = data_valid;
            blk_data  = data_in;
            blk_final = 1'b0; // length block is always the last one
        end
    end

    // state machine
    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            state <= SEQ_DATA;
        end else begin
            case (state)
                SEQ_DATA: begin
                    if (take && last_block) begin
                        state <= SEQ_LEN;
                    end
                end
                SEQ_LEN:  state <= SEQ_DATA; // one cycle for the length block
                default:  state <= SEQ_DATA;
            endcase
        end
    end

    // block counters, cleared as the length block leaves
    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            aad_count  <= '0;
            text_count <= '0;
            text_seen  <= 1'b0;
        end else if (state == SEQ_LEN) begin
            aad_count  <= '0;
            text_count <= '0;
            text_seen  <= 1'b0;
        end else if (take) begin
            if (data_kind == KIND_AAD) begin
                aad_count <= aad_count + 1'b1;
            end else begin
                text_count <= text_count + 1'b1;
                text_seen  <= 1'b1;
            end
        end
    end

    // tag strobe
    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= hash_valid;
        end
    end

    // whitened tag, held until the next message ends
    always_ff @(posedge clk) begin
        if (hash_valid) begin
            auth_tag <= hash ^ tag_mask;
        end
    end

    // aad after text in the same message breaks the length encoding
    a_kind_order : assert property (
        @(posedge clk) disable iff (!reset_l)
        (take && data_kind == KIND_AAD) |-> !text_seen
    ) else $error("auth_sequencer: aad block after a text block");

    // caller must leave the cycle after last_block empty
    a_idle_after_last : assert property (
        @(posedge clk) disable iff (!reset_l)
        (state == SEQ_LEN) |-> !data_valid
    ) else $error("auth_sequencer: data_valid during the length block");

    // tag rises at the second edge after the one that took last_block,
    // so it is first sampled high one edge later
    a_tag_latency : assert property (
        @(posedge clk) disable iff (!reset_l)
        (take && last_block) |=> ##2 tag_valid
    ) else $error("auth_sequencer: tag_valid late or missing");

endmodule

// ==== src/ghash_core.sv ====
// h_key must hold steady for a whole message; hash is only meaningful while hash_valid is high
module ghash_core (
    input  logic              clk,
    input  logic              reset_l,
    input  ghash_pkg::block_t h_key,
    input  logic              blk_valid,
    input  ghash_pkg::block_t blk_data,
    input  logic              blk_final,
    output ghash_pkg::block_t mul_a,
    input  ghash_pkg::block_t mul_p,
    output ghash_pkg::block_t hash,
    output logic              hash_valid
);
    import ghash_pkg::*;

    block_t acc;    // running hash
    logic   in_msg; // a message has started but not ended

    // multiplier operand, the other one is h_key straight from the top
    assign mul_a = acc ^ blk_data;

    // accumulator and control
    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            acc        <= '0;
            hash_valid <= 1'b0;
            in_msg     <= 1'b0;
        end else begin
            hash_valid <= blk_valid && blk_final;
            if (blk_valid) begin
                if (blk_final) begin
                    acc    <= '0;   // ready for the next message
                    in_msg <= 1'b0;
                end else begin
                    acc    <= mul_p; // (acc ^ blk) * h
                    in_msg <= 1'b1;
                end
            end
        end
    end

    // final hash capture
    always_ff @(posedge clk) begin
        if (blk_valid && blk_final) begin
            hash <= mul_p;
        end
    end

    // the sequencer only flags a final block together with its strobe
    a_final_needs_valid : assert property (
        @(posedge clk) disable iff (!reset_l)
        blk_final |-> blk_valid
    ) else $error("ghash_core: blk_final without blk_valid");

    // key changes mid-message would corrupt acc
    a_key_stable : assert property (
        @(posedge clk) disable iff (!reset_l)
        in_msg |-> $stable(h_key)
    ) else $error("ghash_core: h_key changed inside a message");

    // a hash pulse is always one cycle wide, final blocks are never adjacent
    a_hash_pulse : assert property (
        @(posedge clk) disable iff (!reset_l)
        hash_valid |=> !hash_valid
    ) else $error("ghash_core: hash_valid longer than one cycle");

endmodule

// ==== src/gf32_mult.sv ====
// purely combinational, one full 32x32 multiply plus reduction per cycle; long path by design
module gf32_mult (
    input  ghash_pkg::block_t a,
    input  ghash_pkg::block_t b,
    output ghash_pkg::block_t p
);
    import ghash_pkg::*;

    logic [PROD_W-1:0] prod; // carry-less product, degree up to 62
    logic [PROD_W-1:0] red;  // same product while folding down

    // schoolbook carry-less multiply
    // each set bit of a adds a shifted copy of b
    always_comb begin
        prod = '0;
        for (int i = 0; i < BLOCK_W; i++) begin
            if (a[i]) begin
                prod = prod ^ (PROD_W'(b) << i);
            end
        end
    end

    // reduction, top bit first
    // x^j becomes x^(j-32) * FIELD_POLY, which lands at most at bit j-25,
    // so any new high bits are still ahead of the loop and get folded too
    always_comb begin
        red = prod;
        for (int j = PROD_W - 1; j >= BLOCK_W; j--) begin
            if (red[j]) begin
                red[j] = 1'b0;
                red[j-BLOCK_W +: BLOCK_W] = red[j-BLOCK_W +: BLOCK_W] ^ FIELD_POLY;
            end
        end
    end

    assign p = red[BLOCK_W-1:0]; // upper part is zero after folding

endmodule

// ==== src/ghash_pkg.sv ====
// field is fixed at GF(2^32) mod x^32+x^7+x^3+x^2+1, plain bit order (bit 0 = x^0), no parameters
package ghash_pkg;

    // field width, one block per clock
    localparam int BLOCK_W = 32;

    // width of the raw carry-less product before reduction
    localparam int PROD_W = 2 * BLOCK_W - 1;

    // per-kind block counter width, half a length block each
    localparam int COUNT_W = 16;

    // one field element: data block, key, hash or tag
    typedef logic [BLOCK_W-1:0] block_t;

    // block count for aad or text, wraps silently
    typedef logic [COUNT_W-1:0] count_t;

    // low terms of the reduction polynomial
    // x^32 = x^7 + x^3 + x^2 + 1 in this field
    localparam block_t FIELD_POLY = 32'h0000_008D;

    // kind of an incoming block, aad must come before text
    typedef enum logic {
        KIND_AAD  = 1'b0,
        KIND_TEXT = 1'b1
    } kind_e;

    // sequencer states
    typedef enum logic {
        SEQ_DATA = 1'b0, // passing caller blocks through
        SEQ_LEN  = 1'b1  // length block goes out this cycle
    } seq_state_e;

endpackage
